/* axi_line_master.f */
verilog/axi_line_pkg.sv
verilog/burst_req_if.sv
verilog/line_fifo.sv
verilog/request_dispatch.sv
verilog/write_line_engine.sv
verilog/read_line_engine.sv
verilog/axi_line_master.sv
sim/axi_mem_slave.sv
sim/axi_line_master_checker.sv
sim/tb_axi_line_master.sv

/* sim/tb_axi_line_master.sv */
////////////////////////////////////////
// Directed tests against axi_mem_slave.
// Test addresses stay below 4 KB.
////////////////////////////////////////
`timescale 1ns/1ps

module tb_axi_line_master;
  import axi_line_pkg::*;

  localparam int NUM_REQS       = 25;   // Requests issued over all tests.
  localparam int CYCLES_PER_REQ = 200;
  localparam int LINE_BYTES     = LINE_W / 8;

  logic  aclk;
  logic  aresetn;
  logic  ls_valid_in;
  addr_t ls_address;
  op_t   ls_operation;
  line_t ls_data_in;
  logic  ls_ready_in;
  logic  ls_ready_out;
  logic  ls_valid_out;
  line_t ls_data_out;
  logic  awready;
  logic  wready;
  logic  bvalid;
  logic  awvalid;
  addr_t awaddr;
  logic  wvalid;
  beat_t wdata;
  logic  wlast;
  logic  bready;
  logic  arready;
  logic  rvalid;
  beat_t rdata;
  logic  rlast;
  logic  arvalid;
  addr_t araddr;
  logic  rready;

  line_t       got_lines[$];  // Lines taken from the return port.
  int unsigned aw_count = 0;
  int unsigned ar_count = 0;
  int unsigned b_count = 0;

  axi_line_master u_dut (.*);

  axi_mem_slave u_mem (.*);

  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;  // 20 ns period.
  end

  ////////////////////////////////////////
  // Monitors and watchdog
  ////////////////////////////////////////
  always @(posedge aclk) begin
    if (aresetn) begin
      if (ls_valid_out && ls_ready_in) got_lines.push_back(ls_data_out);
      if (awvalid && awready) aw_count++;
      if (arvalid && arready) ar_count++;
      if (bvalid && bready) b_count++;  // Write complete.
    end
  end

  always @(negedge aclk) begin
    if (u_dut.u_checker.fail_count != 0) begin
      $display("A protocol assertion failed.");
      fail_run();
    end
  end

  initial begin
    repeat (NUM_REQS * CYCLES_PER_REQ) @(posedge aclk);
    $display("Timeout: tests did not finish in %0d cycles.", NUM_REQS * CYCLES_PER_REQ);
    fail_run();
  end

  task automatic fail_run();
    $display(">>> FAIL");
    $fatal(1, "Stopped at the first failure.");
  endtask

  task automatic check_value(input string name, input line_t expected, input line_t actual);
    if (expected !== actual) begin
      $display("[ERROR] %s expected 0x%0h actual 0x%0h", name, expected, actual);
      fail_run();
    end
  endtask

  function automatic addr_t line_addr(input addr_t base, input int k);
    return base + addr_t'(k * LINE_BYTES);
  endfunction

  function automatic line_t random_line();
    line_t line;
    for (int i = 0; i < BEATS; i++) line[i*BEAT_W +: BEAT_W] = $urandom();
    return line;
  endfunction

  // Random words into the slave; beat 0 is the lowest word.
  task automatic preload_line(input addr_t addr, output line_t line);
    beat_t word;
    for (int i = 0; i < BEATS; i++) begin
      word = $urandom();
      u_mem.poke_word(addr + addr_t'(i * BEAT_BYTES), word);
      line[i*BEAT_W +: BEAT_W] = word;
    end
  endtask

  task automatic send_request(input op_t op, input addr_t addr, input line_t line);
    @(negedge aclk);
    ls_valid_in  = 1'b1;
    ls_operation = op;
    ls_address   = addr;
    ls_data_in   = line;
    while (!ls_ready_out) @(negedge aclk);  // Ready is stable between edges.
    @(negedge aclk);  // Taken on the rising edge just passed.
    ls_valid_in = 1'b0;
  endtask

  task automatic wait_writes(input int unsigned target);
    while (b_count < target) @(negedge aclk);
  endtask

  task automatic wait_lines(input int n);
    while (got_lines.size() < n) @(negedge aclk);
  endtask

  task automatic check_lines(input line_t expected[$]);
    line_t got;
    foreach (expected[k]) begin
      got = got_lines.pop_front();
      check_value($sformatf("ls_data_out[%0d]", k), expected[k], got);
    end
  endtask

  task automatic check_memory(input addr_t addr, input line_t line);
    addr_t a;
    for (int i = 0; i < BEATS; i++) begin
      a = addr + addr_t'(i * BEAT_BYTES);
      check_value($sformatf("mem[0x%0h]", a), line[i*BEAT_W +: BEAT_W], u_mem.peek_word(a));
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////
  task automatic test_reset();
    check_value("awvalid", 1'b0, awvalid);
    check_value("wvalid", 1'b0, wvalid);
    check_value("arvalid", 1'b0, arvalid);
    check_value("bready", 1'b0, bready);
    check_value("rready", 1'b0, rready);
    check_value("ls_valid_out", 1'b0, ls_valid_out);
    check_value("ls_ready_out", 1'b1, ls_ready_out);
  endtask

  task automatic test_line_write();
    line_t       line;
    int unsigned b_start;
    line    = random_line();
    b_start = b_count;
    send_request(OP_WRITE, 32'h0000_0040, line);
    wait_writes(b_start + 1);
    check_memory(32'h0000_0040, line);
  endtask

  task automatic test_line_read();
    line_t expected[$];
    line_t line;
    for (int k = 0; k < 3; k++) begin
      preload_line(line_addr(32'h0000_0100, k), line);
      expected.push_back(line);
    end
    for (int k = 0; k < 3; k++) send_request(OP_READ, line_addr(32'h0000_0100, k), '0);
    wait_lines(3);
    check_lines(expected);
  endtask

  // Return port held off; only RET_DEPTH reads may start.
  task automatic test_back_pressure();
    line_t       expected[$];
    line_t       line;
    int unsigned ar_start;
    @(negedge aclk);
    ls_ready_in = 1'b0;
    ar_start    = ar_count;
    for (int k = 0; k < 6; k++) begin
      preload_line(line_addr(32'h0000_0200, k), line);
      expected.push_back(line);
    end
    for (int k = 0; k < 6; k++) send_request(OP_READ, line_addr(32'h0000_0200, k), '0);
    while (ar_count - ar_start < RET_DEPTH) @(negedge aclk);
    repeat (100) @(negedge aclk);  // Room for a stray fifth AR.
    check_value("ar handshakes", RET_DEPTH, ar_count - ar_start);
    check_value("ls_valid_out", 1'b1, ls_valid_out);
    ls_ready_in = 1'b1;
    wait_lines(6);
    check_lines(expected);
  endtask

  task automatic test_mixed();
    line_t       wr_lines[$];
    line_t       expected[$];
    line_t       line;
    int unsigned b_start;
    b_start = b_count;
    for (int k = 0; k < 4; k++) begin
      wr_lines.push_back(random_line());
      send_request(OP_WRITE, line_addr(32'h0000_0400, k), wr_lines[k]);
      preload_line(line_addr(32'h0000_0600, k), line);
      expected.push_back(line);
      send_request(OP_READ, line_addr(32'h0000_0600, k), '0);
    end
    wait_lines(4);
    check_lines(expected);
    wait_writes(b_start + 4);  // Read back only after every B.
    for (int k = 0; k < 4; k++) send_request(OP_READ, line_addr(32'h0000_0400, k), '0);
    wait_lines(4);
    check_lines(wr_lines);
  endtask

  task automatic test_unknown_op();
    line_t       expected[$];
    line_t       line;
    int unsigned aw_start;
    int unsigned ar_start;
    aw_start = aw_count;
    ar_start = ar_count;
    send_request(2'b00, 32'h0000_0800, random_line());
    send_request(2'b11, 32'h0000_0820, random_line());
    preload_line(32'h0000_0840, line);
    expected.push_back(line);
    send_request(OP_READ, 32'h0000_0840, '0);
    wait_lines(1);
    repeat (20) @(negedge aclk);
    check_value("aw handshakes", 0, aw_count - aw_start);
    check_value("ar handshakes", 1, ar_count - ar_start);
    check_value("returned lines", 1, got_lines.size());
    check_lines(expected);
  endtask

  initial begin
    void'($urandom(50065));
    aresetn      = 1'b0;
    ls_valid_in  = 1'b0;
    ls_address   = '0;
    ls_operation = '0;
    ls_data_in   = '0;
    ls_ready_in  = 1'b1;
    repeat (5) @(negedge aclk);
    aresetn = 1'b1;
    test_reset();
    test_line_write();
    test_line_read();
    test_back_pressure();
    test_mixed();
    test_unknown_op();
    if (u_dut.u_checker.fail_count != 0) begin
      $display("A protocol assertion failed.");
      fail_run();
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

/* sim/axi_line_master_checker.sv */
////////////////////////////////////////
// Bound into axi_line_master by port name.
////////////////////////////////////////
`timescale 1ns/1ps

module axi_line_master_checker (
  input logic aclk,
  input logic aresetn,
  input logic awvalid,
  input logic awready,
  input logic wvalid,
  input logic wready,
  input logic wlast,
  input logic bvalid,
  input logic bready,
  input logic arvalid,
  input logic arready,
  input logic ls_valid_out,
  input logic ls_ready_in
);
  import axi_line_pkg::*;

  int unsigned fail_count = 0;  // Failed assertions so far.
  beat_idx_t   w_beat;          // Index of the current W beat.
  logic        w_done;          // WLAST taken, B still owed.

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      w_beat <= '0;
      w_done <= 1'b0;
    end else begin
      if (wvalid && wready) w_beat <= w_beat + 1'b1;  // Wraps after beat 7.
      if (wvalid && wready && wlast) begin
        w_done <= 1'b1;
      end else if (bvalid && bready) begin
        w_done <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // Valid holds until its handshake
  ////////////////////////////////////////
  a_aw_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    awvalid && !awready |=> awvalid)
    else begin
      $error("AWVALID dropped before AWREADY.");
      fail_count++;
    end

  a_w_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    wvalid && !wready |=> wvalid)
    else begin
      $error("WVALID dropped before WREADY.");
      fail_count++;
    end

  a_ar_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    arvalid && !arready |=> arvalid)
    else begin
      $error("ARVALID dropped before ARREADY.");
      fail_count++;
    end

  a_ret_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    ls_valid_out && !ls_ready_in |=> ls_valid_out)
    else begin
      $error("Return valid dropped before ready.");
      fail_count++;
    end

  // WLAST marks the eighth beat and no other.
  a_wlast_beat: assert property (@(posedge aclk) disable iff (!aresetn)
    wvalid |-> (wlast == (w_beat == beat_idx_t'(BEATS - 1))))
    else begin
      $error("WLAST not on beat %0d of the burst.", BEATS - 1);
      fail_count++;
    end

  a_bready_order: assert property (@(posedge aclk) disable iff (!aresetn)
    bready |-> w_done)
    else begin
      $error("BREADY high before the WLAST handshake.");
      fail_count++;
    end

endmodule

bind axi_line_master axi_line_master_checker u_checker (.*);

/* sim/axi_mem_slave.sv */
////////////////////////////////////////
// One write and one read burst at a time.
// Memory is 1024 words and wraps every 4 KB.
////////////////////////////////////////
`timescale 1ns/1ps

module axi_mem_slave (
  input  logic                aclk,
  input  logic                aresetn,
  input  logic                awvalid,
  input  axi_line_pkg::addr_t awaddr,
  input  logic                wvalid,
  input  axi_line_pkg::beat_t wdata,
  input  logic                wlast,
  input  logic                bready,
  input  logic                arvalid,
  input  axi_line_pkg::addr_t araddr,
  input  logic                rready,
  output logic                awready = 1'b0,
  output logic                wready = 1'b0,
  output logic                bvalid = 1'b0,
  output logic                arready = 1'b0,
  output logic                rvalid = 1'b0,
  output axi_line_pkg::beat_t rdata = '0,
  output logic                rlast = 1'b0
);
  import axi_line_pkg::*;

  localparam int MEM_WORDS = 1024;

  beat_t     mem [MEM_WORDS];
  addr_t     wr_addr = '0;     // Address of the next W beat.
  addr_t     rd_addr = '0;     // Address of the next R beat.
  beat_idx_t rd_beat = '0;
  logic      aw_taken = 1'b0;  // Write burst open.
  logic      b_pend = 1'b0;    // Last beat stored, response owed.
  logic      b_hold = 1'b0;    // BVALID shown but not taken.
  logic      ar_taken = 1'b0;  // Read burst open.
  logic      r_hold = 1'b0;

  function automatic int word_index(addr_t a);
    return int'((a / BEAT_BYTES) % MEM_WORDS);
  endfunction

  function automatic beat_t peek_word(addr_t a);
    return mem[word_index(a)];
  endfunction

  task automatic poke_word(input addr_t a, input beat_t d);
    mem[word_index(a)] = d;
  endtask

  // High on about three cycles out of four.
  function automatic logic coin();
    return ($urandom % 4) != 0;
  endfunction

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {~16'(i), 16'(i)};  // Fill tied to the word index.
    end
  end

  ////////////////////////////////////////
  // Handshakes, taken at the rising edge
  ////////////////////////////////////////
  always @(posedge aclk) begin
    if (!aresetn) begin
      aw_taken = 1'b0;
      b_pend   = 1'b0;
      b_hold   = 1'b0;
      ar_taken = 1'b0;
      r_hold   = 1'b0;
    end else begin
      if (awvalid && awready) begin
        aw_taken = 1'b1;
        wr_addr  = awaddr;
      end
      if (wvalid && wready) begin
        poke_word(wr_addr, wdata);
        wr_addr = wr_addr + addr_t'(BEAT_BYTES);
        if (wlast) b_pend = 1'b1;  // B only after the last beat.
      end
      b_hold = bvalid && !bready;
      if (bvalid && bready) begin
        b_pend   = 1'b0;
        aw_taken = 1'b0;
      end
      if (arvalid && arready) begin
        ar_taken = 1'b1;
        rd_addr  = araddr;
        rd_beat  = '0;
      end
      r_hold = rvalid && !rready;
      if (rvalid && rready) begin
        rd_addr = rd_addr + addr_t'(BEAT_BYTES);
        rd_beat = rd_beat + 1'b1;
        if (rlast) ar_taken = 1'b0;
      end
    end
  end

  // Outputs change on the falling edge, with random gaps.
  always @(negedge aclk) begin
    awready = aresetn && !aw_taken && coin();
    wready  = aresetn && aw_taken && !b_pend && coin();
    bvalid  = aresetn && b_pend && (b_hold || coin());  // Held once shown.
    arready = aresetn && !ar_taken && coin();
    rvalid  = aresetn && ar_taken && (r_hold || coin());
    rdata   = peek_word(rd_addr);
    rlast   = (rd_beat == beat_idx_t'(BEATS - 1));
  end

endmodule

/* verilog/axi_line_master.sv */
////////////////////////////////////////
// AWLEN/ARLEN, SIZE and BURST are tied off outside.
// No IDs, no WSTRB, responses are not checked.
////////////////////////////////////////
`timescale 1ns/1ps

module axi_line_master (
  input  logic                aclk,
  input  logic                aresetn,
  // Request and return ports.
  input  logic                ls_valid_in,
  input  axi_line_pkg::addr_t ls_address,
  input  axi_line_pkg::op_t   ls_operation,
  input  axi_line_pkg::line_t ls_data_in,
  input  logic                ls_ready_in,
  output logic                ls_ready_out,
  output logic                ls_valid_out,
  output axi_line_pkg::line_t ls_data_out,
  // AXI4 write channels.
  input  logic                awready,
  input  logic                wready,
  input  logic                bvalid,
  output logic                awvalid,
  output axi_line_pkg::addr_t awaddr,
  output logic                wvalid,
  output axi_line_pkg::beat_t wdata,
  output logic                wlast,
  output logic                bready,
  // AXI4 read channels.
  input  logic                arready,
  input  logic                rvalid,
  input  axi_line_pkg::beat_t rdata,
  input  logic                rlast,
  output logic                arvalid,
  output axi_line_pkg::addr_t araddr,
  output logic                rready
);
  import axi_line_pkg::*;

  logic  rd_valid;  // Read hand-off.
  logic  rd_ready;
  addr_t rd_addr;

  burst_req_if u_wr_req ();

  request_dispatch u_dispatch (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .ls_valid_in  (ls_valid_in),
    .ls_address   (ls_address),
    .ls_operation (ls_operation),
    .ls_data_in   (ls_data_in),
    .rd_ready     (rd_ready),
    .ls_ready_out (ls_ready_out),
    .rd_valid     (rd_valid),
    .rd_addr      (rd_addr),
    .wr_req       (u_wr_req.dispatch)
  );

  write_line_engine u_write (
    .aclk    (aclk),
    .aresetn (aresetn),
    .awready (awready),
    .wready  (wready),
    .bvalid  (bvalid),
    .awvalid (awvalid),
    .awaddr  (awaddr),
    .wvalid  (wvalid),
    .wdata   (wdata),
    .wlast   (wlast),
    .bready  (bready),
    .req     (u_wr_req.engine)
  );

  read_line_engine u_read (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .rd_valid     (rd_valid),
    .rd_addr      (rd_addr),
    .arready      (arready),
    .rvalid       (rvalid),
    .rdata        (rdata),
    .rlast        (rlast),
    .ls_ready_in  (ls_ready_in),
    .rd_ready     (rd_ready),
    .arvalid      (arvalid),
    .araddr       (araddr),
    .rready       (rready),
    .ls_valid_out (ls_valid_out),
    .ls_data_out  (ls_data_out)
  );

endmodule

/* verilog/read_line_engine.sv */
////////////////////////////////////////
// A read starts only with a reserved return slot.
// Lines return in request order.
////////////////////////////////////////
`timescale 1ns/1ps

module read_line_engine (
  input  logic                aclk,
  input  logic                aresetn,
  input  logic                rd_valid,
  input  axi_line_pkg::addr_t rd_addr,
  input  logic                arready,
  input  logic                rvalid,
  input  axi_line_pkg::beat_t rdata,
  input  logic                rlast,
  input  logic                ls_ready_in,
  output logic                rd_ready,
  output logic                arvalid,
  output axi_line_pkg::addr_t araddr,
  output logic                rready,
  output logic                ls_valid_out,
  output axi_line_pkg::line_t ls_data_out
);
  import axi_line_pkg::*;

  rd_state_e state;
  addr_t     addr_q;
  line_t     line_q;    // Line being assembled.
  beat_idx_t beat_idx;  // Slot of the next R beat.
  credit_t   credits;   // Free return slots.
  logic      accept;
  logic      ret_push;
  logic      ret_pop;

  assign rd_ready = (state == RD_IDLE) && (credits != '0);
  assign accept   = rd_valid && rd_ready;
  assign arvalid  = (state == RD_ADDR);
  assign araddr   = addr_q;
  assign rready   = (state == RD_DATA);
  assign ret_push = (state == RD_PUSH);
  assign ret_pop  = ls_valid_out && ls_ready_in;

  line_fifo #(
    .WIDTH (LINE_W),
    .DEPTH (RET_DEPTH)
  ) u_ret_fifo (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .push      (ret_push),
    .push_data (line_q),
    .pop       (ret_pop),
    .not_full  (),             // Credits keep it from filling past depth.
    .not_empty (ls_valid_out),
    .pop_data  (ls_data_out)
  );

  ////////////////////////////////////////
  // Credit counter
  ////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      credits <= credit_t'(RET_DEPTH);
    end else begin
      case ({accept, ret_pop})
        2'b10:   credits <= credits - 1'b1;  // Slot reserved.
        2'b01:   credits <= credits + 1'b1;  // Slot freed.
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (accept) addr_q <= rd_addr;
    if (rvalid && rready) line_q[beat_idx*BEAT_W +: BEAT_W] <= rdata;  // Beat i at i.
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state    <= RD_IDLE;
      beat_idx <= '0;
    end else begin
      case (state)
        RD_IDLE: if (accept) state <= RD_ADDR;
        RD_ADDR: begin
          if (arready) begin
            state    <= RD_DATA;
            beat_idx <= '0;
          end
        end
        RD_DATA: begin
          if (rvalid) begin
            beat_idx <= beat_idx + 1'b1;
            if (rlast) state <= RD_PUSH;  // Push next cycle.
          end
        end
        RD_PUSH: state <= RD_IDLE;
        default: state <= RD_IDLE;
      endcase
    end
  end

endmodule

/* verilog/write_line_engine.sv */
////////////////////////////////////////
// One write burst in flight at a time.
// Beat 0 is the lowest word of the line.
////////////////////////////////////////
`timescale 1ns/1ps

module write_line_engine (
  input  logic                aclk,
  input  logic                aresetn,
  input  logic                awready,
  input  logic                wready,
  input  logic                bvalid,
  output logic                awvalid,
  output axi_line_pkg::addr_t awaddr,
  output logic                wvalid,
  output axi_line_pkg::beat_t wdata,
  output logic                wlast,
  output logic                bready,
  burst_req_if.engine         req
);
  import axi_line_pkg::*;

  wr_state_e state;
  addr_t     addr_q;    // Held burst address.
  line_t     line_q;    // Held line, split into beats.
  beat_idx_t beat_idx;  // Current W beat.
  logic      accept;

  assign req.ready = (state == WR_IDLE);
  assign accept    = req.valid && req.ready;

  ////////////////////////////////////////
  // AXI outputs, decoded from state
  ////////////////////////////////////////
  assign awvalid = (state == WR_ADDR);
  assign awaddr  = addr_q;
  assign wvalid  = (state == WR_DATA);
  assign wdata   = line_q[beat_idx*BEAT_W +: BEAT_W];  // Beat i from bit i*32.
  assign wlast   = wvalid && (beat_idx == beat_idx_t'(BEATS - 1));
  assign bready  = (state == WR_RESP);

  // Payload capture on accept.
  always_ff @(posedge aclk) begin
    if (accept) begin
      addr_q <= req.addr;
      line_q <= req.line;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state    <= WR_IDLE;
      beat_idx <= '0;
    end else begin
      case (state)
        WR_IDLE: begin
          if (accept) state <= WR_ADDR;  // AWVALID next cycle.
        end
        WR_ADDR: begin
          if (awready) begin
            state    <= WR_DATA;
            beat_idx <= '0;
          end
        end
        WR_DATA: begin
          if (wready) begin
            beat_idx <= beat_idx + 1'b1;   // One beat per handshake.
            if (wlast) state <= WR_RESP;   // BREADY next cycle.
          end
        end
        WR_RESP: begin
          if (bvalid) state <= WR_IDLE;    // Burst done.
        end
        default: state <= WR_IDLE;
      endcase
    end
  end

endmodule

/* verilog/request_dispatch.sv */
////////////////////////////////////////
// A blocked head stalls every request behind it.
// Unknown op codes are popped with no transfer.
////////////////////////////////////////
`timescale 1ns/1ps

module request_dispatch (
  input  logic                aclk,
  input  logic                aresetn,
  input  logic                ls_valid_in,
  input  axi_line_pkg::addr_t ls_address,
  input  axi_line_pkg::op_t   ls_operation,
  input  axi_line_pkg::line_t ls_data_in,
  input  logic                rd_ready,
  output logic                ls_ready_out,
  output logic                rd_valid,
  output axi_line_pkg::addr_t rd_addr,
  burst_req_if.dispatch       wr_req
);
  import axi_line_pkg::*;

  logic [OP_W+ADDR_W+LINE_W-1:0] req_in;    // {line, addr, op}.
  logic [OP_W+ADDR_W+LINE_W-1:0] req_head;
  logic                          req_push;
  logic                          req_pop;
  logic                          head_valid;
  op_t                           head_op;
  addr_t                         head_addr;
  line_t                         head_line;
  logic                          head_unknown;

  assign req_in   = {ls_data_in, ls_address, ls_operation};
  assign req_push = ls_valid_in && ls_ready_out;

  line_fifo #(
    .WIDTH (OP_W + ADDR_W + LINE_W),
    .DEPTH (REQ_DEPTH)
  ) u_req_fifo (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .push      (req_push),
    .push_data (req_in),
    .pop       (req_pop),
    .not_full  (ls_ready_out),
    .not_empty (head_valid),
    .pop_data  (req_head)
  );

  ////////////////////////////////////////
  // Head decode and routing
  ////////////////////////////////////////
  assign head_op   = req_head[OP_W-1:0];
  assign head_addr = req_head[OP_W +: ADDR_W];
  assign head_line = req_head[OP_W+ADDR_W +: LINE_W];

  assign head_unknown = (head_op != OP_WRITE) && (head_op != OP_READ);

  assign wr_req.valid = head_valid && (head_op == OP_WRITE);  // Toward write engine.
  assign wr_req.addr  = head_addr;
  assign wr_req.line  = head_line;

  assign rd_valid = head_valid && (head_op == OP_READ);       // Toward read engine.
  assign rd_addr  = head_addr;

  // Pop on the engine transfer, or at once for a discarded code.
  assign req_pop = (wr_req.valid && wr_req.ready)
                || (rd_valid && rd_ready)
                || (head_valid && head_unknown);

endmodule

/* verilog/line_fifo.sv */
////////////////////////////////////////
// Head is shown combinationally on pop_data.
// Push when full and pop when empty are ignored.
////////////////////////////////////////
`timescale 1ns/1ps

module line_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 4
) (
  input  logic             aclk,
  input  logic             aresetn,
  input  logic             push,
  input  logic [WIDTH-1:0] push_data,
  input  logic             pop,
  output logic             not_full,
  output logic             not_empty,
  output logic [WIDTH-1:0] pop_data
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];  // Storage.
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;        // Occupancy.
  logic             do_push;
  logic             do_pop;

  assign not_full  = (count != CNT_W'(DEPTH));
  assign not_empty = (count != '0);
  assign do_push   = push && not_full;   // Drop when full.
  assign do_pop    = pop && not_empty;   // Drop when empty.
  assign pop_data  = mem[rd_ptr];

  always_ff @(posedge aclk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers wrap at DEPTH.
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither.
      endcase
    end
  end

endmodule

/* verilog/burst_req_if.sv */
////////////////////////////////////////
// Write request hand-off, valid/ready.
// Payload holds with valid until transfer.
////////////////////////////////////////
`timescale 1ns/1ps

interface burst_req_if;
  import axi_line_pkg::*;

  logic  valid;  // Head of request FIFO is a write.
  logic  ready;  // Write engine idle.
  addr_t addr;   // Line byte address.
  line_t line;   // Write payload.

  modport dispatch (output valid, output addr, output line, input ready);
  modport engine (input valid, input addr, input line, output ready);

endinterface

/* verilog/axi_line_pkg.sv */
////////////////////////////////////////
// Bursts are fixed at 8 beats of 4 bytes, INCR.
// Line addresses must be line-aligned.
////////////////////////////////////////
package axi_line_pkg;

  localparam int ADDR_W     = 32;               // Byte address width.
  localparam int BEAT_W     = 32;               // AXI data width.
  localparam int LINE_W     = 256;              // Line width.
  localparam int BEATS      = LINE_W / BEAT_W;  // Beats per burst.
  localparam int BEAT_IDX_W = 3;
  localparam int BEAT_BYTES = BEAT_W / 8;       // Address step per beat.
  localparam int OP_W       = 2;
  localparam int REQ_DEPTH  = 4;
  localparam int RET_DEPTH  = 4;                // Also the initial credit count.
  localparam int CREDIT_W   = 3;                // Holds 0 to RET_DEPTH.

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [BEAT_W-1:0]     beat_t;
  typedef logic [LINE_W-1:0]     line_t;
  typedef logic [BEAT_IDX_W-1:0] beat_idx_t;
  typedef logic [OP_W-1:0]       op_t;
  typedef logic [CREDIT_W-1:0]   credit_t;

  // Operation codes. Anything else is dropped.
  localparam op_t OP_WRITE = 2'b10;
  localparam op_t OP_READ  = 2'b01;

  typedef enum logic [1:0] {WR_IDLE, WR_ADDR, WR_DATA, WR_RESP} wr_state_e;
  typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA, RD_PUSH} rd_state_e;

endpackage
